// File: tb.f
verilog/dsp_types_pkg.sv
verilog/dsp_regs_pkg.sv
verilog/phase_accumulator.sv
verilog/cordic_rotator.sv
verilog/complex_mixer.sv
verilog/output_select.sv
verilog/capture_fsm.sv
verilog/dsp_top.sv
verification/tb_dsp.sv

// File: run_sim.sh
#!/bin/bash
# compile with verilator, run, and judge the result from the simulation log
rm -f sim.log && \
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dsp -f tb.f \
		-o sim_tb_dsp > build.log 2>&1 && \
	./obj_dir/sim_tb_dsp > sim.log 2>&1
grep -q "^Verification passed$" sim.log && echo "simulation ok" || { echo "simulation FAILED"; exit 1; }

// File: verification/tb_dsp.sv
`timescale 1ns/1ns

module tb_dsp;

	localparam int CAP_ADDR_W = 6;
	// two register stages between the select and the dac port
	localparam int SETTLE = 2;
	localparam int TOL = 8;
	// amp 16384 times the cordic gain of about 1.6468
	localparam int COS_EXP = 26981;
	// scripted tests take roughly 310 cycles
	localparam int TIMEOUT_CYCLES = 4000;

	logic                    dspif = 1'b0;
	logic                    arst_n;
	dsp_regs_pkg::dsp_regs_t regs;
	logic [63:0]             adc;
	logic [255:0]            dac;
	logic [CAP_ADDR_W-1:0]   cap_addr;
	logic [7:0]              cap_we;
	logic [63:0]             cap_data;

	logic [15:0]             lfsr = 16'd65427;
	int                      cycles = 0;
	logic                    started = 1'b0;
	logic                    m_fill = 1'b0;
	logic [CAP_ADDR_W-1:0]   m_addr = '0;
	logic [13:0]             prev_count = '0;
	logic                    count_valid = 1'b0;
	dsp_regs_pkg::dac_sel_e  last_sel = dsp_regs_pkg::DAC_ZERO;
	int                      dac_age = 0;
	logic [255:0]            prev_dac = '0;
	logic                    prev_valid = 1'b0;
	int                      sq_age = 0;
	logic                    sq_seen = 1'b0;

	dsp_top #(
		.CAP_ADDR_W (CAP_ADDR_W),
		.NSTAGE     (16)
	) i_dut (
		.dspif    (dspif),
		.arst_n   (arst_n),
		.regs     (regs),
		.adc      (adc),
		.dac      (dac),
		.cap_addr (cap_addr),
		.cap_we   (cap_we),
		.cap_data (cap_data)
	);

	always #20 dspif = ~dspif;

	task automatic stop_with_failure();
		$display("Verification failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_value(input string name, input logic [255:0] got,
			input logic [255:0] exp);
		$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		stop_with_failure();
	endtask

	task automatic report_issue(input string what);
		$display("[ERROR] %s", what);
		stop_with_failure();
	endtask

	// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_step();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) begin
			lfsr = lfsr ^ 16'hB400;
		end
		return out;
	endfunction

	function automatic logic [63:0] random_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[62:0], lfsr_step()};
		end
		return v;
	endfunction

	function automatic bit near(input logic [15:0] got, input int exp);
		int d;
		d = int'($signed(got)) - exp;
		return d >= -TOL && d <= TOL;
	endfunction

	// q15 complex product of a model oscillator pair with the host step
	function automatic int mixed_re(input int c, input int s);
		return (c * int'(regs.step_re) - s * int'(regs.step_im)) >>> 15;
	endfunction

	function automatic int mixed_im(input int c, input int s);
		return (c * int'(regs.step_im) + s * int'(regs.step_re)) >>> 15;
	endfunction

	task automatic run_cycles(input int n);
		repeat (n) @(negedge dspif);
	endtask

	task automatic pulse_start();
		regs.cap_start = 1'b1;
		@(negedge dspif);
		regs.cap_start = 1'b0;
	endtask

	// write enables rise on the next edge and drop once the fill is done
	task automatic wait_capture_done();
		do begin
			@(negedge dspif);
		end while (cap_we != 8'h00);
	endtask

	task automatic hold_dac_source(input dsp_regs_pkg::dac_sel_e sel, input int n);
		regs.dac_sel = sel;
		run_cycles(n);
	endtask

	always @(posedge dspif) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			report_issue("timeout, the test sequence did not finish within the cycle limit");
		end
	end

	// capture port against the fill sequence
	always @(posedge dspif) begin
		if (!started) begin
			assert (cap_we == 8'h00) else report_value("cap_we", 256'(cap_we), 256'(0));
			assert (dac == '0) else report_value("dac", dac, '0);
		end
		if (!arst_n) begin
			m_fill = 1'b0;
			m_addr = '0;
			count_valid = 1'b0;
		end else begin
			assert (cap_addr == m_addr)
				else report_value("cap_addr", 256'(cap_addr), 256'(m_addr));
			assert (cap_we == {8{m_fill}})
				else report_value("cap_we", 256'(cap_we), 256'({8{m_fill}}));
			if (cap_we == 8'hff && regs.cap_sel == dsp_regs_pkg::CAP_ADC) begin
				assert (cap_data == adc)
					else report_value("cap_data", 256'(cap_data), 256'(adc));
			end
			if (cap_we == 8'hff && regs.cap_sel == dsp_regs_pkg::CAP_COUNT) begin
				for (int k = 0; k < 4; k++) begin
					assert (cap_data[16*k +: 2] == 2'(k))
						else report_value("cap_data lane index", 256'(cap_data), 256'(k));
					assert (cap_data[16*k+2 +: 14] == cap_data[15:2])
						else report_value("cap_data count", 256'(cap_data), 256'(cap_data[15:2]));
				end
				if (count_valid) begin
					assert (cap_data[15:2] == prev_count + 14'd1)
						else report_value("cap_data count step", 256'(cap_data[15:2]),
							256'(14'(prev_count + 14'd1)));
				end
				prev_count = cap_data[15:2];
				count_valid = 1'b1;
			end else begin
				count_valid = 1'b0;
			end
			// next state from the strobe seen at this edge
			if (regs.cap_start) begin
				started = 1'b1;
				m_fill = 1'b1;
				m_addr = '0;
			end else if (m_fill) begin
				if (m_addr == '1) begin
					m_fill = 1'b0;
				end else begin
					m_addr = m_addr + 1'b1;
				end
			end
		end
	end

	// dac patterns once the select has been stable long enough
	always @(posedge dspif) begin
		if (regs.dac_sel != last_sel) begin
			dac_age = 0;
		end else if (dac_age < 1000) begin
			dac_age = dac_age + 1;
		end
		last_sel = regs.dac_sel;
		if (!arst_n || dac_age < SETTLE) begin
			prev_valid = 1'b0;
			sq_seen = 1'b0;
			sq_age = 0;
		end else begin
			if (regs.dac_sel != dsp_regs_pkg::DAC_RAMP) begin
				assert (dac == {16{dac[15:0]}})
					else report_value("dac lanes", dac, {16{dac[15:0]}});
			end
			case (regs.dac_sel)
				dsp_regs_pkg::DAC_ZERO: begin
					assert (dac == '0) else report_value("dac", dac, '0);
				end
				dsp_regs_pkg::DAC_RAMP: begin
					for (int k = 0; k < dsp_types_pkg::LANES; k++) begin
						assert (dac[16*k +: 4] == 4'(k))
							else report_value("dac ramp index", dac, 256'(k));
						assert (dac[16*k+4 +: 12] == dac[15:4])
							else report_value("dac ramp lane", dac, 256'(dac[15:4]));
					end
					if (prev_valid) begin
						assert (dac[15:4] == prev_dac[15:4] + 12'd1)
							else report_value("dac ramp step", 256'(dac[15:4]),
								256'(12'(prev_dac[15:4] + 12'd1)));
					end
				end
				dsp_regs_pkg::DAC_SQUARE: begin
					assert (dac[15:0] == {dac[15], {15{dac[0]}}})
						else report_value("dac square lane", 256'(dac[15:0]),
							256'({dac[15], {15{dac[0]}}}));
					sq_age = sq_age + 1;
					if (prev_valid && dac[15:0] != prev_dac[15:0]) begin
						assert ({dac[15], dac[0]} == {prev_dac[15], prev_dac[0]} + 2'd1)
							else report_value("square count", 256'({dac[15], dac[0]}),
								256'(2'({prev_dac[15], prev_dac[0]} + 2'd1)));
						if (sq_seen) begin
							assert (32'(sq_age) == regs.test_period + 32'd1)
								else report_value("square period", 256'(sq_age),
									256'(regs.test_period + 32'd1));
						end
						sq_seen = 1'b1;
						sq_age = 0;
					end
				end
				dsp_regs_pkg::DAC_PHASE: begin
					if (prev_valid) begin
						assert (dac[15:0] - prev_dac[15:0] == regs.freq[31:16] ||
								dac[15:0] - prev_dac[15:0] == regs.freq[31:16] + 16'd1)
							else report_value("dac phase step",
								256'(16'(dac[15:0] - prev_dac[15:0])),
								256'(regs.freq[31:16]));
					end
				end
				dsp_regs_pkg::DAC_COS: begin
					assert (near(dac[15:0], COS_EXP))
						else report_value("dac cos", 256'(dac[15:0]), 256'(16'(COS_EXP)));
				end
				dsp_regs_pkg::DAC_SIN: begin
					assert (near(dac[15:0], 0)) else report_value("dac sin", 256'(dac[15:0]), 256'(0));
				end
				dsp_regs_pkg::DAC_MIX_I: begin
					assert (near(dac[15:0], mixed_re(COS_EXP, 0)))
						else report_value("dac mix i", 256'(dac[15:0]),
							256'(16'(mixed_re(COS_EXP, 0))));
				end
				default: begin
					assert (near(dac[15:0], mixed_im(COS_EXP, 0)))
						else report_value("dac mix q", 256'(dac[15:0]),
							256'(16'(mixed_im(COS_EXP, 0))));
				end
			endcase
			prev_dac = dac;
			prev_valid = 1'b1;
		end
	end

	initial begin
		regs = '0;
		regs.amp = 16'sd16384;
		regs.step_re = 16'sd32767;
		regs.step_im = 16'sd0;
		regs.dac_sel = dsp_regs_pkg::DAC_ZERO;
		regs.cap_sel = dsp_regs_pkg::CAP_COUNT;
		adc = '0;
		arst_n = 1'b0;
		run_cycles(10);
		arst_n = 1'b1;
		run_cycles(4);

		// count capture, restarted partway through the first fill
		pulse_start();
		run_cycles(20);
		pulse_start();
		wait_capture_done();
		run_cycles(6);

		adc = random_bits(64);
		regs.cap_sel = dsp_regs_pkg::CAP_ADC;
		run_cycles(1);
		pulse_start();
		wait_capture_done();
		run_cycles(6);

		hold_dac_source(dsp_regs_pkg::DAC_ZERO, 8);
		hold_dac_source(dsp_regs_pkg::DAC_RAMP, 20);
		regs.test_period = 32'(random_bits(3)) + 32'd1;
		run_cycles(2);
		hold_dac_source(dsp_regs_pkg::DAC_SQUARE, 4 * (int'(regs.test_period) + 1) + 8);

		// freq is still zero here, so the phase sits at zero
		hold_dac_source(dsp_regs_pkg::DAC_COS, 8);
		hold_dac_source(dsp_regs_pkg::DAC_SIN, 8);
		hold_dac_source(dsp_regs_pkg::DAC_MIX_I, 8);
		hold_dac_source(dsp_regs_pkg::DAC_MIX_Q, 8);

		regs.freq = 32'(random_bits(32));
		run_cycles(2);
		hold_dac_source(dsp_regs_pkg::DAC_PHASE, 20);
		hold_dac_source(dsp_regs_pkg::DAC_ZERO, 4);

		$display("Verification passed");
		$finish;
	end

endmodule

// File: verilog/dsp_top.sv
`timescale 1ns/1ns

module dsp_top #(
	parameter int CAP_ADDR_W = 13,
	parameter int NSTAGE = 16
) (
	input  logic                    dspif,
	input  logic                    arst_n,
	input  dsp_regs_pkg::dsp_regs_t regs,
	input  logic [63:0]             adc,
	output logic [255:0]            dac,
	output logic [CAP_ADDR_W-1:0]   cap_addr,
	output logic [7:0]              cap_we,
	output logic [63:0]             cap_data
);

	dsp_types_pkg::osc_t osc;
	dsp_types_pkg::iq_t  cs;
	dsp_types_pkg::iq_t  step;
	dsp_types_pkg::iq_t  mix;

	assign step.re = regs.step_re;
	assign step.im = regs.step_im;

	phase_accumulator i_phase (
		.dspif       (dspif),
		.arst_n      (arst_n),
		.freq        (regs.freq),
		.test_period (regs.test_period),
		.osc         (osc)
	);

	cordic_rotator #(
		.WIDTH  ($bits(dsp_types_pkg::sample_t)),
		.NSTAGE (NSTAGE)
	) i_cordic (
		.dspif    (dspif),
		.arst_n   (arst_n),
		.amp      (regs.amp),
		.phase    (osc.phase),
		.run      (osc.run),
		.cs       (cs),
		.cs_valid ()
	);

	complex_mixer i_mixer (
		.dspif  (dspif),
		.arst_n (arst_n),
		.x      (cs),
		.y      (step),
		.z      (mix)
	);

	output_select i_select (
		.dspif    (dspif),
		.arst_n   (arst_n),
		.dac_sel  (regs.dac_sel),
		.cap_sel  (regs.cap_sel),
		.osc      (osc),
		.cs       (cs),
		.mix      (mix),
		.adc      (adc),
		.dac      (dac),
		.cap_data (cap_data)
	);

	capture_fsm #(
		.ADDR_W (CAP_ADDR_W)
	) i_capture (
		.dspif  (dspif),
		.arst_n (arst_n),
		.start  (regs.cap_start),
		.addr   (cap_addr),
		.we     (cap_we)
	);

endmodule

// File: verilog/capture_fsm.sv
`timescale 1ns/1ns

module capture_fsm #(
	parameter int ADDR_W = 13
) (
	input  logic              dspif,
	input  logic              arst_n,
	input  logic              start,
	output logic [ADDR_W-1:0] addr,
	output logic [7:0]        we
);

	dsp_regs_pkg::cap_state_e state;
	logic                     last;

	assign last = &addr;

	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			state <= dsp_regs_pkg::CAP_IDLE;
			addr  <= '0;
		end else if (start) begin
			// restart from any state, even mid-fill
			state <= dsp_regs_pkg::CAP_FILL;
			addr  <= '0;
		end else begin
			case (state)
				dsp_regs_pkg::CAP_FILL: begin
					if (last) begin
						state <= dsp_regs_pkg::CAP_LOCKED;
					end else begin
						addr <= addr + ADDR_W'(1);
					end
				end
				default: begin
					state <= state;
				end
			endcase
		end
	end

	// write every byte lane while filling
	assign we = {8{state == dsp_regs_pkg::CAP_FILL}};

endmodule

// File: verilog/output_select.sv
`timescale 1ns/1ns

module output_select (
	input  logic                     dspif,
	input  logic                     arst_n,
	input  dsp_regs_pkg::dac_sel_e   dac_sel,
	input  dsp_regs_pkg::cap_sel_e   cap_sel,
	input  dsp_types_pkg::osc_t      osc,
	input  dsp_types_pkg::iq_t       cs,
	input  dsp_types_pkg::iq_t       mix,
	input  logic [63:0]              adc,
	output logic [255:0]             dac,
	output logic [63:0]              cap_data
);

	dsp_types_pkg::dac_word_t dac_next;
	dsp_types_pkg::dac_word_t dac_stage;
	dsp_types_pkg::cap_word_t cap_next;

	always_comb begin
		for (int k = 0; k < dsp_types_pkg::LANES; k++) begin
			case (dac_sel)
				dsp_regs_pkg::DAC_SQUARE: dac_next[k] = {osc.square[1], {15{osc.square[0]}}};
				dsp_regs_pkg::DAC_PHASE:  dac_next[k] = osc.phase;
				dsp_regs_pkg::DAC_COS:    dac_next[k] = cs.re;
				dsp_regs_pkg::DAC_SIN:    dac_next[k] = cs.im;
				// lane index in the low nibble
				dsp_regs_pkg::DAC_RAMP:   dac_next[k] = {osc.ramp, 4'(k)};
				dsp_regs_pkg::DAC_MIX_I:  dac_next[k] = mix.re;
				dsp_regs_pkg::DAC_MIX_Q:  dac_next[k] = mix.im;
				default:                  dac_next[k] = '0;
			endcase
		end
	end

	always_comb begin
		case (cap_sel)
			dsp_regs_pkg::CAP_ADC: begin
				cap_next = adc;
			end
			dsp_regs_pkg::CAP_COUNT: begin
				for (int k = 0; k < dsp_types_pkg::CAP_LANES; k++) begin
					cap_next[k] = {osc.count, 2'(k)};
				end
			end
			dsp_regs_pkg::CAP_COS: begin
				cap_next = {dsp_types_pkg::CAP_LANES{cs.re}};
			end
			default: begin
				cap_next = {dsp_types_pkg::CAP_LANES{cs.im}};
			end
		endcase
	end

	// dac gets an extra output stage, capture does not
	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			dac_stage <= '0;
			dac       <= '0;
			cap_data  <= '0;
		end else begin
			dac_stage <= dac_next;
			dac       <= dac_stage;
			cap_data  <= cap_next;
		end
	end

endmodule

// File: verilog/complex_mixer.sv
`timescale 1ns/1ns

module complex_mixer (
	input  logic               dspif,
	input  logic               arst_n,
	input  dsp_types_pkg::iq_t x,
	input  dsp_types_pkg::iq_t y,
	output dsp_types_pkg::iq_t z
);

	logic signed [31:0] rr;
	logic signed [31:0] ii;
	logic signed [31:0] ri;
	logic signed [31:0] ir;
	logic signed [32:0] re_sum;
	logic signed [32:0] im_sum;

	assign re_sum = 33'(rr) - 33'(ii);
	assign im_sum = 33'(ri) + 33'(ir);

	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			rr <= '0;
			ii <= '0;
			ri <= '0;
			ir <= '0;
			z  <= '0;
		end else begin
			rr <= x.re * y.re;
			ii <= x.im * y.im;
			ri <= x.re * y.im;
			ir <= x.im * y.re;
			// q15 step, drop the doubled sign bit
			z.re <= re_sum[30:15];
			z.im <= im_sum[30:15];
		end
	end

endmodule

// File: verilog/cordic_rotator.sv
`timescale 1ns/1ns

module cordic_rotator #(
	parameter int WIDTH = 16,
	parameter int NSTAGE = 16
) (
	input  logic                   dspif,
	input  logic                   arst_n,
	input  dsp_types_pkg::sample_t amp,
	input  logic [15:0]            phase,
	input  logic                   run,
	output dsp_types_pkg::iq_t     cs,
	output logic                   cs_valid
);

	// two guard bits for the cordic gain
	localparam int XW = WIDTH + 2;
	// 16-bit turn plus 4 fraction bits
	localparam int ZW = 20;

	// atan(2^-i) in units of 2^-20 turn, good for up to 16 stages
	localparam int ATAN_LUT [16] = '{
		131072, 77376, 40884, 20753, 10417, 5213, 2607, 1304,
		652, 326, 163, 81, 41, 20, 10, 5
	};

	logic signed [XW-1:0] x [NSTAGE+1];
	logic signed [XW-1:0] y [NSTAGE+1];
	logic signed [ZW-1:0] z [NSTAGE+1];
	logic [NSTAGE:0]      run_d;
	logic                 flip;

	function automatic dsp_types_pkg::sample_t sat(input logic signed [XW-1:0] v);
		logic [XW-WIDTH:0] top;
		top = v[XW-1:WIDTH-1];
		if (top == '0 || top == '1) begin
			sat = v[WIDTH-1:0];
		end else if (v[XW-1]) begin
			sat = {1'b1, {(WIDTH-1){1'b0}}};
		end else begin
			sat = {1'b0, {(WIDTH-1){1'b1}}};
		end
	endfunction

	// second and third quadrant
	assign flip = phase[15] ^ phase[14];

	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i <= NSTAGE; i++) begin
				x[i] <= '0;
				y[i] <= '0;
				z[i] <= '0;
			end
		end else begin
			// fold by 180 degrees so the residual angle stays within +-90
			x[0] <= flip ? -XW'(amp) : XW'(amp);
			y[0] <= '0;
			z[0] <= {phase[15] ^ flip, phase[14:0], 4'b0000};
			for (int i = 0; i < NSTAGE; i++) begin
				if (z[i][ZW-1]) begin
					x[i+1] <= x[i] + (y[i] >>> i);
					y[i+1] <= y[i] - (x[i] >>> i);
					z[i+1] <= z[i] + ZW'(ATAN_LUT[i]);
				end else begin
					x[i+1] <= x[i] - (y[i] >>> i);
					y[i+1] <= y[i] + (x[i] >>> i);
					z[i+1] <= z[i] - ZW'(ATAN_LUT[i]);
				end
			end
		end
	end

	// run walks beside the data, one flag per stage
	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			run_d <= '0;
		end else begin
			run_d <= {run_d[NSTAGE-1:0], run};
		end
	end

	assign cs.re    = sat(x[NSTAGE]);
	assign cs.im    = sat(y[NSTAGE]);
	assign cs_valid = run_d[NSTAGE];

endmodule

// File: verilog/phase_accumulator.sv
`timescale 1ns/1ns

module phase_accumulator (
	input  logic                dspif,
	input  logic                arst_n,
	input  logic [31:0]         freq,
	input  logic [31:0]         test_period,
	output dsp_types_pkg::osc_t osc
);

	logic [31:0] phase_acc;
	logic [31:0] period_cnt;
	logic [1:0]  square;
	logic [11:0] ramp;
	logic [13:0] count;
	logic        run;

	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			phase_acc  <= '0;
			period_cnt <= '0;
			square     <= '0;
			ramp       <= '0;
			count      <= '0;
			run        <= 1'b0;
		end else begin
			phase_acc <= phase_acc + freq;
			// reload at zero, so one square step per test_period+1 cycles
			if (period_cnt == '0) begin
				period_cnt <= test_period;
				square     <= square + 2'd1;
			end else begin
				period_cnt <= period_cnt - 32'd1;
			end
			ramp  <= ramp + 12'd1;
			count <= count + 14'd1;
			run   <= 1'b1;
		end
	end

	always_comb begin
		osc.phase  = phase_acc[31:16];
		osc.square = square;
		osc.ramp   = ramp;
		osc.count  = count;
		osc.run    = run;
	end

endmodule

// File: verilog/dsp_regs_pkg.sv
package dsp_regs_pkg;

	typedef enum logic [2:0] {
		DAC_SQUARE,
		DAC_PHASE,
		DAC_COS,
		DAC_SIN,
		DAC_RAMP,
		DAC_MIX_I,
		DAC_MIX_Q,
		DAC_ZERO
	} dac_sel_e;

	typedef enum logic [1:0] {
		CAP_ADC,
		CAP_COUNT,
		CAP_COS,
		CAP_SIN
	} cap_sel_e;

	typedef enum logic [1:0] {
		CAP_IDLE,
		CAP_FILL,
		CAP_LOCKED
	} cap_state_e;

	// host registers, all levels except cap_start
	typedef struct packed {
		logic [31:0]            freq;
		dsp_types_pkg::sample_t amp;
		dsp_types_pkg::sample_t step_re;
		dsp_types_pkg::sample_t step_im;
		logic [31:0]            test_period;
		dac_sel_e               dac_sel;
		cap_sel_e               cap_sel;
		logic                   cap_start;
	} dsp_regs_t;

endpackage

// File: verilog/dsp_types_pkg.sv
package dsp_types_pkg;

	localparam int LANES = 16;
	localparam int CAP_LANES = 4;

	typedef logic signed [15:0] sample_t;

	// complex sample, re in the upper half
	typedef struct packed {
		sample_t re;
		sample_t im;
	} iq_t;

	// everything the timing block hands to the datapath
	typedef struct packed {
		logic [15:0] phase;
		logic [1:0]  square;
		logic [11:0] ramp;
		logic [13:0] count;
		logic        run;
	} osc_t;

	// lane 0 sits in the low bits
	typedef logic [LANES-1:0][15:0] dac_word_t;
	typedef logic [CAP_LANES-1:0][15:0] cap_word_t;

endpackage
